//--- design/mips_pkg.sv
`default_nettype none

package mips_pkg;

	// datapath widths
	localparam int word_w      = 32;
	localparam int reg_addr_w  = 5;
	localparam int dmem_addr_w = 7;

	typedef logic [word_w-1:0]     word_t;
	typedef logic [reg_addr_w-1:0] reg_addr_t;

	// primary opcodes, ir[31:26]
	localparam logic [5:0] op_special = 6'h00;
	localparam logic [5:0] op_j       = 6'h02;
	localparam logic [5:0] op_jal     = 6'h03;
	localparam logic [5:0] op_beq     = 6'h04;
	localparam logic [5:0] op_bne     = 6'h05;
	localparam logic [5:0] op_addi    = 6'h08;
	localparam logic [5:0] op_lw      = 6'h23;
	localparam logic [5:0] op_sw      = 6'h2b;

	// function codes under op_special, ir[5:0]
	localparam logic [5:0] fn_sll = 6'h00;
	localparam logic [5:0] fn_srl = 6'h02;
	localparam logic [5:0] fn_jr  = 6'h08;
	localparam logic [5:0] fn_add = 6'h20;
	localparam logic [5:0] fn_sub = 6'h22;
	localparam logic [5:0] fn_and = 6'h24;
	localparam logic [5:0] fn_or  = 6'h25;
	localparam logic [5:0] fn_slt = 6'h2a;

	typedef enum logic [2:0] {
		alu_add = 3'd0,
		alu_sub = 3'd1,
		alu_and = 3'd2,
		alu_or  = 3'd3,
		alu_slt = 3'd4,
		alu_sll = 3'd5,
		alu_srl = 3'd6
	} alu_op_t;

	// next pc selection
	typedef enum logic [1:0] {
		pc_seq    = 2'd0, // pc + 4
		pc_branch = 2'd1, // pc + 4 + imm*4 when condition holds
		pc_jump   = 2'd2, // {pc[31:28], target, 2'b00}
		pc_reg    = 2'd3  // rs
	} pc_src_t;

	localparam word_t reset_pc = 32'h0000_0000;

	// link register for jal
	localparam reg_addr_t reg_ra = 5'd31;

endpackage

`default_nettype wire

//--- design/instr_decoder.sv
`default_nettype none

module instr_decoder (
	input  mips_pkg::word_t     ir,
	output mips_pkg::reg_addr_t rs,
	output mips_pkg::reg_addr_t rt,
	output mips_pkg::reg_addr_t rd,
	output logic [4:0]          shamt,
	output mips_pkg::word_t     imm_ext,
	output logic [25:0]         jump_target,
	output logic                reg_write,
	output logic                use_imm,
	output logic                mem_read,
	output logic                mem_write,
	output logic                branch_eq,
	output logic                branch_ne,
	output logic                link,
	output mips_pkg::alu_op_t   alu_op,
	output mips_pkg::pc_src_t   pc_src
);
	import mips_pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;

	assign opcode      = ir[31:26];
	assign funct       = ir[5:0];
	assign rs          = ir[25:21];
	assign rt          = ir[20:16];
	assign shamt       = ir[10:6];
	assign imm_ext     = {{16{ir[15]}}, ir[15:0]};
	assign jump_target = ir[25:0];

	always_comb begin
		// defaults decode as a nop
		reg_write = 1'b0;
		use_imm   = 1'b0;
		mem_read  = 1'b0;
		mem_write = 1'b0;
		branch_eq = 1'b0;
		branch_ne = 1'b0;
		link      = 1'b0;
		alu_op    = alu_add;
		pc_src    = pc_seq;
		rd        = ir[15:11];

		case (opcode)
			op_special: begin
				if (ir != '0) begin // all-zero word is a nop, not sll $0
					reg_write = 1'b1;
					case (funct)
						fn_sll: alu_op = alu_sll;
						fn_srl: alu_op = alu_srl;
						fn_add: alu_op = alu_add;
						fn_sub: alu_op = alu_sub;
						fn_and: alu_op = alu_and;
						fn_or:  alu_op = alu_or;
						fn_slt: alu_op = alu_slt;
						fn_jr: begin
							reg_write = 1'b0;
							pc_src    = pc_reg;
						end
						default: reg_write = 1'b0; // unknown funct
					endcase
				end
			end
			op_addi: begin
				reg_write = 1'b1;
				use_imm   = 1'b1;
				rd        = ir[20:16];
			end
			op_lw: begin
				reg_write = 1'b1;
				use_imm   = 1'b1;
				mem_read  = 1'b1;
				rd        = ir[20:16];
			end
			op_sw: begin
				use_imm   = 1'b1;
				mem_write = 1'b1;
			end
			op_beq: begin
				branch_eq = 1'b1;
				pc_src    = pc_branch;
			end
			op_bne: begin
				branch_ne = 1'b1;
				pc_src    = pc_branch;
			end
			op_j: pc_src = pc_jump;
			op_jal: begin
				pc_src    = pc_jump;
				link      = 1'b1;
				reg_write = 1'b1;
				rd        = reg_ra;
			end
			default: ; // unknown opcode falls through as nop
		endcase
	end

endmodule

`default_nettype wire

//--- design/register_file.sv
`default_nettype none

module register_file (
	input  logic                clk,
	input  logic                rst_n,
	input  mips_pkg::reg_addr_t rs_addr,
	input  mips_pkg::reg_addr_t rt_addr,
	input  mips_pkg::reg_addr_t wr_addr,
	input  logic                wr_en,
	input  mips_pkg::word_t     wr_data,
	output mips_pkg::word_t     rs_data,
	output mips_pkg::word_t     rt_data
);
	import mips_pkg::*;

	// register zero has no storage
	word_t regs [1:31];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	always_comb begin
		rs_data = '0;
		rt_data = '0;
		if (rs_addr != '0) begin
			rs_data = regs[rs_addr];
		end
		if (rt_addr != '0) begin
			rt_data = regs[rt_addr];
		end
	end

endmodule

`default_nettype wire

//--- design/alu.sv
`default_nettype none

module alu (
	input  mips_pkg::word_t   op_a,
	input  mips_pkg::word_t   op_b,
	input  logic [4:0]        shamt,
	input  mips_pkg::alu_op_t alu_op,
	output mips_pkg::word_t   result,
	output logic              zero
);
	import mips_pkg::*;

	word_t sum;
	word_t diff;
	logic  lt;

	assign sum  = op_a + op_b;
	assign diff = op_a - op_b;
	assign lt   = $signed(op_a) < $signed(op_b);

	// raw operand compare, branches feed rs and rt straight in
	assign zero = (op_a == op_b);

	always_comb begin
		case (alu_op)
			alu_add: result = sum;
			alu_sub: result = diff;
			alu_and: result = op_a & op_b;
			alu_or:  result = op_a | op_b;
			alu_slt: result = {{(word_w-1){1'b0}}, lt};
			alu_sll: result = op_b << shamt;
			alu_srl: result = op_b >> shamt; // logical, zero fill
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- design/pc_unit.sv
`default_nettype none

module pc_unit (
	input  logic              clk,
	input  logic              rst_n,
	input  mips_pkg::pc_src_t pc_src,
	input  logic              branch_eq,
	input  logic              branch_ne,
	input  logic              eq,
	input  mips_pkg::word_t   imm_ext,
	input  logic [25:0]       jump_target,
	input  mips_pkg::word_t   rs_data,
	output mips_pkg::word_t   pc,
	output mips_pkg::word_t   pc_plus4
);
	import mips_pkg::*;

	word_t pc_next;
	word_t branch_target;
	word_t jump_addr;
	logic  taken;

	assign pc_plus4      = pc + 32'd4;
	assign branch_target = pc_plus4 + {imm_ext[word_w-3:0], 2'b00};
	assign jump_addr     = {pc[31:28], jump_target, 2'b00};

	assign taken = (branch_eq && eq) || (branch_ne && !eq);

	always_comb begin
		case (pc_src)
			pc_seq:    pc_next = pc_plus4;
			pc_branch: pc_next = taken ? branch_target : pc_plus4;
			pc_jump:   pc_next = jump_addr;
			pc_reg:    pc_next = rs_data; // jr
			default:   pc_next = pc_plus4;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= reset_pc;
		end else begin
			pc <= pc_next;
		end
	end

endmodule

`default_nettype wire

//--- design/single_cycle_mips.sv
`default_nettype none

module single_cycle_mips (
	input  logic                                clk,
	input  logic                                rst_n,
	output mips_pkg::word_t                     ir_addr,
	input  mips_pkg::word_t                     ir,
	input  mips_pkg::word_t                     read_data_mem,
	output logic                                cen,
	output logic                                wen,
	output logic                                oen,
	output logic [mips_pkg::dmem_addr_w-1:0]    a,
	output mips_pkg::word_t                     data_to_mem
);
	import mips_pkg::*;

	reg_addr_t  rs_addr;
	reg_addr_t  rt_addr;
	reg_addr_t  wr_addr;
	logic [4:0] shamt;
	word_t      imm_ext;
	logic [25:0] jump_target;
	logic       reg_write;
	logic       use_imm;
	logic       mem_read;
	logic       mem_write;
	logic       branch_eq;
	logic       branch_ne;
	logic       link;
	alu_op_t    alu_op;
	pc_src_t    pc_src;

	word_t rs_data;
	word_t rt_data;
	word_t alu_b;
	word_t alu_result;
	logic  alu_zero;
	word_t pc_plus4;
	word_t wr_data;

	instr_decoder u_decoder (
		.ir          (ir),
		.rs          (rs_addr),
		.rt          (rt_addr),
		.rd          (wr_addr),
		.shamt       (shamt),
		.imm_ext     (imm_ext),
		.jump_target (jump_target),
		.reg_write   (reg_write),
		.use_imm     (use_imm),
		.mem_read    (mem_read),
		.mem_write   (mem_write),
		.branch_eq   (branch_eq),
		.branch_ne   (branch_ne),
		.link        (link),
		.alu_op      (alu_op),
		.pc_src      (pc_src)
	);

	register_file u_regs (
		.clk     (clk),
		.rst_n   (rst_n),
		.rs_addr (rs_addr),
		.rt_addr (rt_addr),
		.wr_addr (wr_addr),
		.wr_en   (reg_write),
		.wr_data (wr_data),
		.rs_data (rs_data),
		.rt_data (rt_data)
	);

	// immediate path also forms the lw/sw byte address
	assign alu_b = use_imm ? imm_ext : rt_data;

	alu u_alu (
		.op_a   (rs_data),
		.op_b   (alu_b),
		.shamt  (shamt),
		.alu_op (alu_op),
		.result (alu_result),
		.zero   (alu_zero)
	);

	pc_unit u_pc (
		.clk         (clk),
		.rst_n       (rst_n),
		.pc_src      (pc_src),
		.branch_eq   (branch_eq),
		.branch_ne   (branch_ne),
		.eq          (alu_zero),
		.imm_ext     (imm_ext),
		.jump_target (jump_target),
		.rs_data     (rs_data),
		.pc          (ir_addr),
		.pc_plus4    (pc_plus4)
	);

	always_comb begin
		if (mem_read)  wr_data = read_data_mem;
		else if (link) wr_data = pc_plus4; // jal return address
		else           wr_data = alu_result;
	end

	// word address out of the byte address
	assign a           = alu_result[dmem_addr_w+1:2];
	assign data_to_mem = rt_data;

	// strobes are active low, held idle while in reset
	assign cen = !rst_n || !(mem_read || mem_write);
	assign wen = !rst_n || !mem_write;
	assign oen = !rst_n || !mem_read;

endmodule

`default_nettype wire

//--- testbench/tb_single_cycle_mips.sv
`default_nettype none

module tb_single_cycle_mips;
	timeunit 1ns;
	timeprecision 100ps;

	import mips_pkg::*;

	localparam int reset_cycles = 16;
	localparam int run_cycles   = 400;
	localparam int tail_timeout = 200;

	logic                   clk = 1'b0;
	logic                   rst_n;
	word_t                  ir_addr;
	word_t                  ir;
	word_t                  read_data_mem;
	logic                   cen;
	logic                   wen;
	logic                   oen;
	logic [dmem_addr_w-1:0] a;
	word_t                  data_to_mem;

	word_t imem [0:63];
	word_t dmem [0:127];

	// reference model state
	word_t mregs [0:31];
	word_t mdmem [0:127];
	word_t mpc;

	integer     seed;
	int         errs [5];
	string      test_names [5] = '{"reset", "control_flow", "stores", "loads", "write_back"};
	logic [5:0] alu_fns [7] = '{fn_sll, fn_srl, fn_add, fn_sub, fn_and, fn_or, fn_slt};
	bit         tail_phase;
	bit         seen [0:31];
	int         seen_count;
	int         n_loads;
	int         n_stores;

	single_cycle_mips dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.ir_addr       (ir_addr),
		.ir            (ir),
		.read_data_mem (read_data_mem),
		.cen           (cen),
		.wen           (wen),
		.oen           (oen),
		.a             (a),
		.data_to_mem   (data_to_mem)
	);

	always #2 clk = ~clk;

	assign ir            = imem[ir_addr[7:2]]; // 64 words, wraps
	assign read_data_mem = (!cen && !oen) ? dmem[a] : '0;

	always @(posedge clk) begin
		if (!cen && !wen) begin
			dmem[a] <= data_to_mem;
		end
	end

	function automatic logic [6:0] word_index(input word_t byte_addr);
		return byte_addr[8:2];
	endfunction

	task automatic check_value(input int t, input string name, input word_t got, input word_t exp);
		assert (got === exp) else begin
			$display("ERROR at %0t: %s = %0h, expected %0h", $time, name, got, exp);
			errs[t]++;
		end
	endtask

	task automatic check_strobes(input int t, input logic c, input logic w, input logic o);
		check_value(t, "cen", cen, c);
		check_value(t, "wen", wen, w);
		check_value(t, "oen", oen, o);
	endtask

	task automatic build_program();
		word_t r;
		int    kind;
		for (int i = 0; i < 64; i++) begin
			r    = $random(seed);
			kind = $unsigned($random(seed)) % 16;
			if (i < 8) begin
				imem[i] = {op_addi, 5'd0, 5'(i + 1), r[15:0]};
			end else begin
				case (kind)
					0, 1, 2, 3, 4, 5:
						imem[i] = {op_special, r[25:6], alu_fns[$unsigned($random(seed)) % 7]};
					6, 7:    imem[i] = {op_addi, r[25:0]};
					8:       imem[i] = {op_lw, r[25:0]};
					9:       imem[i] = {op_sw, r[25:0]};
					10:      imem[i] = {op_beq, r[25:16], {8{r[7]}}, r[7:0]};
					11:      imem[i] = {op_bne, r[25:16], {8{r[7]}}, r[7:0]};
					12:      imem[i] = {op_j, 20'd0, r[5:0]}; // stay inside 64 words
					13:      imem[i] = {op_jal, 20'd0, r[5:0]};
					14:      imem[i] = {op_special, r[25:21], 15'd0, fn_jr};
					default: imem[i] = '0;
				endcase
			end
		end
		for (int i = 0; i < 128; i++) begin
			dmem[i]  = 32'h9e37_79b1 * (i + 1);
			mdmem[i] = dmem[i];
		end
	endtask

	// one instruction of the reference model
	task automatic step_model();
		word_t      ins;
		word_t      vs;
		word_t      vt;
		word_t      imm;
		word_t      npc;
		word_t      wval;
		logic [4:0] wdst;
		logic       wr;
		ins  = imem[mpc[7:2]];
		vs   = mregs[ins[25:21]];
		vt   = mregs[ins[20:16]];
		imm  = {{16{ins[15]}}, ins[15:0]};
		npc  = mpc + 32'd4;
		wdst = ins[20:16];
		wval = '0;
		wr   = 1'b0;
		case (ins[31:26])
			op_special: begin
				wdst = ins[15:11];
				wr   = (ins != '0);
				case (ins[5:0])
					fn_sll:  wval = vt << ins[10:6];
					fn_srl:  wval = vt >> ins[10:6];
					fn_add:  wval = vs + vt;
					fn_sub:  wval = vs - vt;
					fn_and:  wval = vs & vt;
					fn_or:   wval = vs | vt;
					fn_slt:  wval = ($signed(vs) < $signed(vt)) ? 32'd1 : 32'd0;
					fn_jr: begin
						wr  = 1'b0;
						npc = vs;
					end
					default: wr = 1'b0;
				endcase
			end
			op_addi: begin
				wr   = 1'b1;
				wval = vs + imm;
			end
			op_lw: begin
				wr   = 1'b1;
				wval = mdmem[word_index(vs + imm)];
			end
			op_sw:  mdmem[word_index(vs + imm)] = vt;
			op_beq: if (vs == vt) npc = mpc + 32'd4 + (imm << 2);
			op_bne: if (vs != vt) npc = mpc + 32'd4 + (imm << 2);
			op_j:   npc = {mpc[31:28], ins[25:0], 2'b00};
			op_jal: begin
				npc  = {mpc[31:28], ins[25:0], 2'b00};
				wr   = 1'b1;
				wdst = 5'd31;
				wval = mpc + 32'd4;
			end
			default: ;
		endcase
		if (wr && wdst != 5'd0) mregs[wdst] = wval;
		mpc = npc;
	endtask

	// compare the outputs of the current cycle against the model
	task automatic check_cycle();
		word_t      ins;
		word_t      vs;
		word_t      vt;
		logic [6:0] idx;
		ins = imem[mpc[7:2]];
		vs  = mregs[ins[25:21]];
		vt  = mregs[ins[20:16]];
		idx = word_index(vs + {{16{ins[15]}}, ins[15:0]});
		check_value(tail_phase ? 4 : 1, "ir_addr", ir_addr, mpc);
		if (ins[31:26] == op_sw) begin
			check_strobes(tail_phase ? 4 : 2, 1'b0, 1'b0, 1'b1);
			check_value(tail_phase ? 4 : 2, "a", a, idx);
			check_value(tail_phase ? 4 : 2, "data_to_mem", data_to_mem, vt);
			n_stores++;
			if (tail_phase && !seen[ins[20:16]]) begin
				seen[ins[20:16]] = 1'b1;
				seen_count++;
			end
		end else if (ins[31:26] == op_lw) begin
			check_strobes(tail_phase ? 4 : 3, 1'b0, 1'b1, 1'b0);
			check_value(tail_phase ? 4 : 3, "a", a, idx);
			check_value(tail_phase ? 4 : 3, "read_data_mem", read_data_mem, mdmem[idx]);
			n_loads++;
		end else begin
			check_strobes(tail_phase ? 4 : 2, 1'b1, 1'b1, 1'b1); // idle cycle
		end
	endtask

	task automatic report_test(input int t, input string detail);
		$display("test %0d %-12s %s, %0d errors%s", t + 1, test_names[t],
			errs[t] == 0 ? "ok" : "failed", errs[t], detail);
	endtask

	initial begin
		int    failed;
		int    total;
		int    waited;
		word_t first_word;
		seed       = 32'h155f5bff;
		rst_n      = 1'b0;
		tail_phase = 1'b0;
		seen_count = 0;
		n_loads    = 0;
		n_stores   = 0;
		mpc        = reset_pc;
		for (int i = 0; i < 32; i++) begin
			mregs[i] = '0;
			seen[i]  = 1'b0;
		end
		build_program();

		// memory ops sit at pc 0 while in reset, strobes must still stay idle
		first_word = imem[0];
		imem[0]    = {op_sw, 5'd0, 5'd0, 16'd0};
		for (int i = 0; i < reset_cycles; i++) begin
			@(negedge clk);
			check_value(0, "ir_addr", ir_addr, reset_pc);
			check_strobes(0, 1'b1, 1'b1, 1'b1);
			@(posedge clk);
			if (i % 2 == 0) imem[0] <= {op_lw, 5'd0, 5'd0, 16'd0};
			else            imem[0] <= {op_sw, 5'd0, 5'd0, 16'd0};
		end
		imem[0] <= first_word;
		rst_n   <= 1'b1;

		for (int cyc = 0; cyc < run_cycles; cyc++) begin
			@(negedge clk);
			if (cyc == 0) begin // first fetch after reset
				check_value(0, "ir_addr", ir_addr, reset_pc);
				check_strobes(0, 1'b1, 1'b1, 1'b1);
			end
			check_cycle();
			@(posedge clk);
			step_model();
		end
		report_test(0, "");
		report_test(1, $sformatf(", %0d cycles", run_cycles));
		report_test(2, $sformatf(", %0d stores", n_stores));
		report_test(3, $sformatf(", %0d loads", n_loads));

		// tail: sw $r to word r, then jump back to word 0
		for (int i = 0; i < 64; i++) begin
			imem[i] <= (i < 32) ? {op_sw, 5'd0, 5'(i), 16'(4 * i)} : {op_j, 26'd0};
		end
		tail_phase = 1'b1;
		waited     = 0;
		while (seen_count < 32 && waited < tail_timeout) begin
			@(negedge clk);
			check_cycle();
			@(posedge clk);
			step_model();
			waited++;
		end
		if (seen_count < 32) begin
			$display("timeout: tail program stored only %0d of 32 registers in %0d cycles",
				seen_count, waited);
			errs[4]++;
		end
		report_test(4, $sformatf(", %0d registers stored", seen_count));

		failed = 0;
		total  = 0;
		for (int i = 0; i < 5; i++) begin
			if (errs[i] != 0) failed++;
			total += errs[i];
		end
		$display("%0d tests, %0d passed, %0d failed, %0d errors", 5, 5 - failed, failed, total);
		if (total == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
design/mips_pkg.sv
design/instr_decoder.sv
design/register_file.sv
design/alu.sv
design/pc_unit.sv
design/single_cycle_mips.sv
testbench/tb_single_cycle_mips.sv

//--- Bender.yml
package:
  name: single_cycle_mips

sources:
  # package first, top level last
  - files:
      - design/mips_pkg.sv
      - design/instr_decoder.sv
      - design/register_file.sv
      - design/alu.sv
      - design/pc_unit.sv
      - design/single_cycle_mips.sv
  - target: test
    files:
      - testbench/tb_single_cycle_mips.sv
